// File: build.f
+incdir+logic
logic/decode_pkg.sv
logic/special_decoder.sv
logic/opcode_decoder.sv
logic/main_decoder.sv
logic/decode_stage.sv
bench/decode_checker.sv
bench/decode_tb.sv

// File: bench/decode_tb.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_tb import decode_pkg::*; ();

    localparam int num_tests  = 6;
    localparam int timeout_ns = num_tests * 20 * 8;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        in_valid;
    logic        stall;
    logic        flush;
    decode_out_t out;
    logic        out_valid;

    decode_stage dut_i (.clk(clk), .reset(reset), .instr(instr), .in_valid(in_valid),
        .stall(stall), .flush(flush), .out(out), .out_valid(out_valid));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped by watchdog");
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    initial begin
        wait (dut_i.checker_i.fail_count != 0);
        stop_on_error("a protocol assertion in the bound checker failed");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic decode_out_t expect_decode(input logic [31:0] w);
        decode_out_t e;
        logic [5:0]  op;
        op = w[31:26];
        e  = '{ctl: clear_ctl, default: '0};
        if (op == OP_SPECIAL) begin
            case (w[5:0])
                FN_ADD, FN_ADDU: e.ctl.alu_op = ALU_ADD;
                FN_SUB, FN_SUBU: e.ctl.alu_op = ALU_SUB;
                FN_AND:          e.ctl.alu_op = ALU_AND;
                FN_OR:           e.ctl.alu_op = ALU_OR;
                FN_XOR:          e.ctl.alu_op = ALU_XOR;
                FN_NOR:          e.ctl.alu_op = ALU_NOR;
                FN_SLT:          e.ctl.alu_op = ALU_SLT;
                FN_SLTU:         e.ctl.alu_op = ALU_SLTU;
                FN_SLL:          e.ctl.alu_op = ALU_SLL;
                FN_SRL:          e.ctl.alu_op = ALU_SRL;
                FN_SRA:          e.ctl.alu_op = ALU_SRA;
                FN_JR, FN_JALR:  e.ctl.pc_src = PC_JUMP_REG;
                default:         e.ctl.exc_chk = EXC_RESERVED;
            endcase
            e.ctl.write_reg = (w[5:0] != FN_JR);
            e.ctl.reg_src   = (w[5:0] == FN_JALR) ? REG_SRC_LINK : REG_SRC_ALU;
            if (w[5:0] == FN_ADD || w[5:0] == FN_SUB)
                e.ctl.exc_chk = EXC_OVERFLOW;
        end else begin
            case (op)
                OP_J, OP_JAL:                    e.ctl.pc_src = PC_JUMP;
                OP_BEQ, OP_BEQL:                 e.ctl.cond = COND_EQ;
                OP_BNE, OP_BNEL:                 e.ctl.cond = COND_NE;
                OP_BLEZ, OP_BLEZL:               e.ctl.cond = COND_LEZ;
                OP_BGTZ, OP_BGTZL:               e.ctl.cond = COND_GTZ;
                OP_ADDI, OP_ADDIU, OP_LW, OP_SW: e.ctl.alu_op = ALU_ADD;
                OP_SLTI:                         e.ctl.alu_op = ALU_SLT;
                OP_SLTIU:                        e.ctl.alu_op = ALU_SLTU;
                OP_ANDI:                         e.ctl.alu_op = ALU_AND;
                OP_ORI:                          e.ctl.alu_op = ALU_OR;
                OP_XORI:                         e.ctl.alu_op = ALU_XOR;
                OP_LUI:                          e.ctl.alu_op = ALU_LUI;
                default:                         e.ctl.exc_chk = EXC_RESERVED;
            endcase
            if (op == OP_JAL) begin
                e.ctl.write_reg = 1'b1;
                e.ctl.reg_src   = REG_SRC_LINK;
                e.ctl.dest_sel  = DEST_LINK;
            end
            if (e.ctl.cond != COND_NONE) begin
                e.ctl.pc_src = PC_BRANCH;
                e.ctl.likely = op[4];       // likely forms sit at 0x14 to 0x17.
            end
            if (e.ctl.alu_op != ALU_NONE || e.ctl.cond != COND_NONE)
                e.ctl.imm = {{16{w[15]}}, w[15:0]};
            if (op inside {OP_ANDI, OP_ORI, OP_XORI})
                e.ctl.imm = {16'h0000, w[15:0]};
            if (op == OP_LUI)
                e.ctl.imm = {w[15:0], 16'h0000};
            e.ctl.use_imm = (e.ctl.alu_op != ALU_NONE);
            if (e.ctl.use_imm && op != OP_SW) begin
                e.ctl.write_reg = 1'b1;
                e.ctl.dest_sel  = DEST_RT;
            end
            e.ctl.read_mem  = (op == OP_LW);
            e.ctl.write_mem = (op == OP_SW);
            if (op == OP_ADDI)
                e.ctl.exc_chk = EXC_OVERFLOW;
        end
        if (e.ctl.exc_chk == EXC_RESERVED) begin
            e.ctl         = clear_ctl;
            e.ctl.exc_chk = EXC_RESERVED;
        end
        e.rs    = w[25:21];
        e.rt    = w[20:16];
        e.shamt = w[10:6];
        if (e.ctl.write_reg)
            e.dest = (e.ctl.dest_sel == DEST_RT) ? w[20:16] :
                     (e.ctl.dest_sel == DEST_LINK) ? 5'(`DECODE_LINK_REG) : w[15:11];
        return e;
    endfunction

    function automatic logic [31:0] rand_word(input logic [5:0] op);
        return {op, 26'($urandom)};     // random registers and immediate.
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(input logic [31:0] w);
        instr    = w;
        in_valid = 1'b1;
    endtask

    task automatic check_out(input logic [31:0] w);
        decode_out_t e;
        e = expect_decode(w);
        assert (out_valid === 1'b1)
            else stop_on_error($sformatf("mismatch out_valid: got %h, expected 1", out_valid));
        assert (out === e)
            else stop_on_error($sformatf("mismatch out (instr %h): got %h, expected %h",
                w, out, e));
    endtask

    task automatic decode_one(input logic [31:0] w);
        drive(w);
        next_cycle();
        in_valid = 1'b0;
        check_out(w);
    endtask

    task automatic sweep_opcode(input logic [5:0] op);
        decode_one(rand_word(op) & 32'hffff_7fff);
        decode_one(rand_word(op) | 32'h0000_8000);  // negative immediate.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_test();
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            if (i == 4)
                reset = 1'b0;
            assert (out_valid === 1'b0)
                else stop_on_error($sformatf("mismatch out_valid: got %h, expected 0", out_valid));
            assert (out.ctl === clear_ctl)
                else stop_on_error($sformatf("mismatch out.ctl: got %h, expected %h",
                    out.ctl, clear_ctl));
        end
    endtask

    task automatic rtype_test();
        funct_e      f;
        logic [31:0] w;
        f = f.first();
        repeat (f.num()) begin
            w      = rand_word(OP_SPECIAL);
            w[5:0] = f;
            decode_one(w);
            f = f.next();
        end
    endtask

    task automatic imm_test();
        opcode_e ops[10] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                             OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};
        foreach (ops[i])
            sweep_opcode(ops[i]);
    endtask

    task automatic control_test();
        opcode_e ops[10] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ,
                             OP_BGTZ, OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL};
        foreach (ops[i])
            sweep_opcode(ops[i]);
    endtask

    task automatic reserved_test();
        logic [31:0] w;
        decode_one(rand_word(6'h1c));   // special2.
        decode_one(rand_word(6'h10));   // cop0.
        decode_one(rand_word(6'h01));
        w      = rand_word(OP_SPECIAL);
        w[5:0] = 6'h3f;
        decode_one(w);
    endtask

    task automatic protocol_test();
        logic [31:0] w[4];
        w = '{rand_word(OP_ADDIU), rand_word(OP_ORI), rand_word(OP_LW), rand_word(OP_JAL)};
        drive(w[0]);
        for (int i = 1; i < 4; i++) begin
            next_cycle();
            check_out(w[i-1]);
            drive(w[i]);
        end
        next_cycle();
        check_out(w[3]);
        drive(w[0]);                    // waits upstream during the stall.
        stall = 1'b1;
        repeat (3) begin
            next_cycle();
            check_out(w[3]);
        end
        stall = 1'b0;
        next_cycle();
        check_out(w[0]);
        stall = 1'b1;
        flush = 1'b1;
        next_cycle();
        stall    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        assert (out_valid === 1'b0)
            else stop_on_error($sformatf("mismatch out_valid: got %h, expected 0", out_valid));
    endtask

    initial begin
        void'($urandom(51));
        reset    = 1'b1;
        instr    = '0;
        in_valid = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        reset_test();
        rtype_test();
        imm_test();
        control_test();
        reserved_test();
        protocol_test();
        next_cycle();
        if (dut_i.checker_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

// File: bench/decode_checker.sv
`timescale 1ns/10ps

module decode_checker import decode_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        flush,
    input decode_out_t out,
    input logic        out_valid
);

    int fail_count = 0;

    flush_empties: assert property (@(posedge clk) disable iff (reset) flush |=> !out_valid)
        else begin
            $error("out_valid still high one cycle after flush");
            fail_count++;
        end

    // a stalled stage keeps its word.
    stall_holds: assert property (@(posedge clk) disable iff (reset)
        stall && !flush |=> $stable(out) && $stable(out_valid))
        else begin
            $error("out changed while stall was held");
            fail_count++;
        end

    reserved_quiet: assert property (@(posedge clk) disable iff (reset)
        out.ctl.exc_chk == EXC_RESERVED |-> !out.ctl.write_reg)
        else begin
            $error("reserved encoding left write_reg set");
            fail_count++;
        end

endmodule

bind decode_stage decode_checker checker_i (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush), .out(out), .out_valid(out_valid)
);

// File: logic/decode_stage.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_stage import decode_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`DECODE_XLEN-1:0] instr,
    input  logic                    in_valid,
    input  logic                    stall,
    input  logic                    flush,
    output decode_out_t             out,
    output logic                    out_valid
);

    decode_out_t dec;

    main_decoder decoder_i (
        .instr (instr),
        .dec   (dec)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out       <= '{ctl: clear_ctl, default: '0};
        end else if (flush) begin
            out_valid <= 1'b0;          // wins over stall.
        end else if (!stall) begin
            out_valid <= in_valid;
            if (in_valid)
                out <= dec;
        end
        // stall without flush holds both out and out_valid.
    end

endmodule

// File: logic/main_decoder.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module main_decoder import decode_pkg::*; (
    input  logic [`DECODE_XLEN-1:0] instr,
    output decode_out_t             dec
);

    opcode_e                  opcode;
    decode_ctl_t              special_ctl;
    decode_ctl_t              opcode_ctl;
    decode_ctl_t              sel_ctl;
    logic [`DECODE_REG_W-1:0] rs;
    logic [`DECODE_REG_W-1:0] rt;
    logic [`DECODE_REG_W-1:0] rd;

    assign opcode = opcode_e'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    special_decoder special_i (
        .instr (instr),
        .ctl   (special_ctl)
    );

    opcode_decoder opcode_i (
        .instr (instr),
        .ctl   (opcode_ctl)
    );

    assign sel_ctl = (opcode == OP_SPECIAL) ? special_ctl : opcode_ctl;

    always_comb begin
        dec.ctl   = sel_ctl;
        dec.rs    = rs;
        dec.rt    = rt;
        dec.shamt = instr[10:6];

        // reserved words travel as a bubble that only carries the exception.
        if (sel_ctl.exc_chk == EXC_RESERVED) begin
            dec.ctl         = clear_ctl;
            dec.ctl.exc_chk = EXC_RESERVED;
        end

        case (dec.ctl.dest_sel)
            DEST_RT:   dec.dest = rt;
            DEST_LINK: dec.dest = `DECODE_REG_W'(`DECODE_LINK_REG);
            default:   dec.dest = rd;
        endcase

        if (!dec.ctl.write_reg)
            dec.dest = '0;  // keeps hazard compares quiet.
    end

endmodule

// File: logic/opcode_decoder.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module opcode_decoder import decode_pkg::*; (
    input  logic [`DECODE_XLEN-1:0] instr,
    output decode_ctl_t             ctl
);

    opcode_e                 opcode;
    logic [`DECODE_XLEN-1:0] sign_imm;
    logic [`DECODE_XLEN-1:0] zero_imm;
    logic [`DECODE_XLEN-1:0] upper_imm;

    assign opcode    = opcode_e'(instr[31:26]);
    assign sign_imm  = {{(`DECODE_XLEN-16){instr[15]}}, instr[15:0]};
    assign zero_imm  = {{(`DECODE_XLEN-16){1'b0}}, instr[15:0]};
    assign upper_imm = {instr[15:0], 16'h0000}; // lui.

    always_comb begin
        ctl = clear_ctl;

        case (opcode)
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // jumps and branches
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            OP_J: ctl.pc_src = PC_JUMP;

            OP_JAL: begin
                ctl.pc_src    = PC_JUMP;
                ctl.write_reg = 1'b1;
                ctl.reg_src   = REG_SRC_LINK;
                ctl.dest_sel  = DEST_LINK;
            end

            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
            OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL: begin
                ctl.pc_src = PC_BRANCH;
                ctl.imm    = sign_imm;   // word offset, shifted later.
                ctl.likely = opcode inside {OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL};
                case (opcode)
                    OP_BEQ, OP_BEQL:   ctl.cond = COND_EQ;
                    OP_BNE, OP_BNEL:   ctl.cond = COND_NE;
                    OP_BLEZ, OP_BLEZL: ctl.cond = COND_LEZ;
                    default:           ctl.cond = COND_GTZ;
                endcase
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // immediate arithmetic and loads
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                ctl.use_imm   = 1'b1;
                ctl.write_reg = 1'b1;
                ctl.dest_sel  = DEST_RT;
                ctl.imm       = sign_imm;
                ctl.read_mem  = (opcode == OP_LW);

                case (opcode)
                    OP_SLTI:  ctl.alu_op = ALU_SLT;
                    OP_SLTIU: ctl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctl.alu_op = ALU_AND;
                    OP_ORI:   ctl.alu_op = ALU_OR;
                    OP_XORI:  ctl.alu_op = ALU_XOR;
                    OP_LUI:   ctl.alu_op = ALU_LUI;
                    default:  ctl.alu_op = ALU_ADD; // addi, addiu, lw address.
                endcase

                // logical ops take the raw 16 bits.
                if (opcode inside {OP_ANDI, OP_ORI, OP_XORI})
                    ctl.imm = zero_imm;
                if (opcode == OP_LUI)
                    ctl.imm = upper_imm;
                if (opcode == OP_ADDI)
                    ctl.exc_chk = EXC_OVERFLOW;
            end

            OP_SW: begin
                ctl.alu_op    = ALU_ADD;
                ctl.use_imm   = 1'b1;
                ctl.imm       = sign_imm;
                ctl.write_mem = 1'b1;
            end

            // special is handled elsewhere, so it lands here too.
            default: ctl.exc_chk = EXC_RESERVED;
        endcase
    end

endmodule

// File: logic/special_decoder.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module special_decoder import decode_pkg::*; (
    input  logic [`DECODE_XLEN-1:0] instr,
    output decode_ctl_t             ctl
);

    funct_e funct;

    assign funct = funct_e'(instr[5:0]);

    always_comb begin
        ctl           = clear_ctl;
        ctl.write_reg = 1'b1;   // nearly every r-type writes rd.
        ctl.dest_sel  = DEST_RD;

        case (funct)
            FN_ADD, FN_ADDU: ctl.alu_op = ALU_ADD;
            FN_SUB, FN_SUBU: ctl.alu_op = ALU_SUB;
            FN_AND:          ctl.alu_op = ALU_AND;
            FN_OR:           ctl.alu_op = ALU_OR;
            FN_XOR:          ctl.alu_op = ALU_XOR;
            FN_NOR:          ctl.alu_op = ALU_NOR;
            FN_SLT:          ctl.alu_op = ALU_SLT;
            FN_SLTU:         ctl.alu_op = ALU_SLTU;
            FN_SLL:          ctl.alu_op = ALU_SLL;
            FN_SRL:          ctl.alu_op = ALU_SRL;
            FN_SRA:          ctl.alu_op = ALU_SRA;

            FN_JR: begin
                ctl.pc_src    = PC_JUMP_REG;
                ctl.write_reg = 1'b0;
            end

            FN_JALR: begin
                ctl.pc_src  = PC_JUMP_REG;
                ctl.reg_src = REG_SRC_LINK; // return address goes to rd.
            end

            default: begin
                ctl.write_reg = 1'b0;
                ctl.exc_chk   = EXC_RESERVED;
            end
        endcase

        // only the trapping forms check overflow.
        if (funct == FN_ADD || funct == FN_SUB)
            ctl.exc_chk = EXC_OVERFLOW;
    end

endmodule

// File: logic/decode_pkg.sv
`include "decode_settings.svh"

package decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, // r-type, see funct.
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_BEQL    = 6'h14,
        OP_BNEL    = 6'h15,
        OP_BLEZL   = 6'h16,
        OP_BGTZL   = 6'h17,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control selectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI,
        ALU_NONE
    } alu_op_e;

    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_JUMP_REG} pc_src_e;
    typedef enum logic [2:0] {COND_NONE, COND_EQ, COND_NE, COND_LEZ, COND_GTZ} cond_e;
    typedef enum logic {REG_SRC_ALU, REG_SRC_LINK} reg_src_e; // link is pc + 8.
    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_sel_e;
    typedef enum logic [1:0] {EXC_NONE, EXC_OVERFLOW, EXC_RESERVED} exc_chk_e;

    typedef struct packed {
        alu_op_e                  alu_op;
        logic                     use_imm;   // second alu operand is imm.
        logic                     write_reg;
        dest_sel_e                dest_sel;
        reg_src_e                 reg_src;
        pc_src_e                  pc_src;
        cond_e                    cond;
        logic                     likely;    // annul delay slot if not taken.
        logic                     read_mem;
        logic                     write_mem;
        exc_chk_e                 exc_chk;
        logic [`DECODE_XLEN-1:0]  imm;
    } decode_ctl_t;

    typedef struct packed {
        decode_ctl_t              ctl;
        logic [`DECODE_REG_W-1:0] rs;
        logic [`DECODE_REG_W-1:0] rt;
        logic [`DECODE_REG_W-1:0] dest;      // zero when nothing is written.
        logic [4:0]               shamt;
    } decode_out_t;

    // a bubble: no write, no memory access, fall through to next pc.
    localparam decode_ctl_t clear_ctl = '{
        alu_op:    ALU_NONE,
        use_imm:   1'b0,
        write_reg: 1'b0,
        dest_sel:  DEST_RD,
        reg_src:   REG_SRC_ALU,
        pc_src:    PC_NEXT,
        cond:      COND_NONE,
        likely:    1'b0,
        read_mem:  1'b0,
        write_mem: 1'b0,
        exc_chk:   EXC_NONE,
        imm:       '0
    };

endpackage

// File: logic/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word and register widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// instruction and data word.
`define DECODE_XLEN 32

// register index, also the width of rs, rt, rd.
`define DECODE_REG_W 5

// return address register for jal.
`define DECODE_LINK_REG 31

`endif
